// File: sources.f
common/l1_cache_pkg.sv
src/way_store.sv
src/snoop_unit.sv
cache_ctrl/l1_cache_ctrl.sv
src/l1_cache_top.sv
verification/mem_model.sv
verification/l1_cache_tb.sv

// File: Makefile
# Verilator build and run for the L1 cache testbench

VERILATOR ?= verilator
TOP       ?= l1_cache_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	-./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "TEST RESULT: PASS" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/l1_cache_tb.sv
`default_nettype none

module l1_cache_tb;
	import l1_cache_pkg::*;

	localparam int IMAGE_DEPTH = 8192;
	localparam int N_DIRECTED = 10;
	localparam int N_RANDOM = 400;
	// Longest op is a read miss with the slowest memory turnaround
	localparam int MAX_OP_CYCLES = 16;
	localparam int TIMEOUT_CYCLES = (N_DIRECTED + N_RANDOM) * MAX_OP_CYCLES + 50;
	localparam logic [7:0] SET_A = 8'h3C;
	localparam logic [7:0] SET_B = 8'hA5;

	typedef struct packed {
		addr_t addr;
		logic  write;
		word_t wdata;
		word_t exp_data;
	} expect_t;

	logic     clk;
	logic     rst_n;
	logic     req_valid;
	cpu_req_t req;
	logic     ready;
	logic     rsp_valid;
	cpu_rsp_t rsp;
	logic     mem_req_valid;
	mem_req_t mem_req;
	logic     mem_rsp_valid;
	mem_rsp_t mem_rsp;
	logic     snoop_valid;
	addr_t    snoop_addr;

	word_t   mem_image [IMAGE_DEPTH];
	expect_t pending [$];
	integer  seed;
	int      cycle_cnt = 0;
	int      issue_cnt = 0;
	int      rsp_cnt = 0;
	int      mem_req_cnt = 0;
	int      accept_cycle = 0;
	int      last_latency = 0;
	logic    mem_seen = 1'b0;

	l1_cache_top u_l1_cache_top (
		.clk_i           (clk),
		.rst_n           (rst_n),
		.i_req_valid     (req_valid),
		.i_req           (req),
		.o_ready         (ready),
		.o_rsp_valid     (rsp_valid),
		.o_rsp           (rsp),
		.o_mem_req_valid (mem_req_valid),
		.o_mem_req       (mem_req),
		.i_mem_rsp_valid (mem_rsp_valid),
		.i_mem_rsp       (mem_rsp),
		.i_snoop_valid   (snoop_valid),
		.i_snoop_addr    (snoop_addr)
	);

	mem_model #(
		.IMAGE_DEPTH (IMAGE_DEPTH)
	) u_mem_model (
		.clk_i       (clk),
		.i_req_valid (mem_req_valid),
		.i_req       (mem_req),
		.i_image     (mem_image),
		.o_rsp_valid (mem_rsp_valid),
		.o_rsp       (mem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Initial memory word is unique for every address
	function automatic word_t fill_word(input int a);
		return word_t'(a) * 32'h0001_0003 ^ 32'h5A00_00A5;
	endfunction

	// Reference model of a read
	function automatic word_t expected_word(input addr_t a);
		return mem_image[int'(a) % IMAGE_DEPTH];
	endfunction

	function automatic addr_t make_addr(input int tag_sel, input logic set_sel, input int word);
		addr_fields_t f;
		f.tag = tag_t'(tag_sel);
		f.index = set_sel ? index_t'(SET_B) : index_t'(SET_A);
		f.word_sel = word_sel_t'(word);
		return addr_t'(f);
	endfunction

	task automatic abort_run();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic issue_request(input addr_t addr, input logic write, input word_t wdata);
		while (!ready) begin
			@(negedge clk);
		end
		req_valid = 1'b1;
		req.addr = addr;
		req.write = write;
		req.wdata = wdata;
		issue_cnt++;
		@(negedge clk);
		req_valid = 1'b0;
		while (rsp_cnt < issue_cnt) begin
			@(negedge clk);
		end
	endtask

	task automatic issue_snoop(input addr_t addr);
		while (!ready) begin
			@(negedge clk);
		end
		snoop_valid = 1'b1;
		snoop_addr = addr;
		@(negedge clk);
		snoop_valid = 1'b0;
	endtask

	// Samples at the rising edge before the DUT registers update
	always @(posedge clk) begin : monitor
		expect_t head;
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("ERROR: timeout, the run did not finish within %0d cycles",
				TIMEOUT_CYCLES);
			abort_run();
		end
		if (rst_n) begin
			if (mem_req_valid) begin
				assert (pending.size() == 1 && !mem_seen) else begin
					$display("ERROR: memory request at time %0t without a request needing one",
						$time);
					abort_run();
				end
				assert (mem_req.addr == pending[0].addr) else begin
					$display("MISMATCH time=%0t o_mem_req.addr got=%h expected=%h",
						$time, mem_req.addr, pending[0].addr);
					abort_run();
				end
				assert (mem_req.write == pending[0].write) else begin
					$display("MISMATCH time=%0t o_mem_req.write got=%b expected=%b",
						$time, mem_req.write, pending[0].write);
					abort_run();
				end
				if (pending[0].write) begin
					assert (mem_req.wdata == pending[0].wdata) else begin
						$display("MISMATCH time=%0t o_mem_req.wdata got=%h expected=%h",
							$time, mem_req.wdata, pending[0].wdata);
						abort_run();
					end
				end
				mem_seen = 1'b1;
				mem_req_cnt++;
			end
			if (rsp_valid) begin
				assert (pending.size() == 1) else begin
					$display("ERROR: response at time %0t without an accepted request", $time);
					abort_run();
				end
				head = pending.pop_front();
				if (!head.write) begin
					assert (rsp.data == head.exp_data) else begin
						$display("MISMATCH time=%0t o_rsp.data got=%h expected=%h",
							$time, rsp.data, head.exp_data);
						abort_run();
					end
				end
				last_latency = cycle_cnt - 1 - accept_cycle;
				rsp_cnt++;
			end
			// The cache refuses new requests until the current one is answered
			if (ready) begin
				assert (pending.size() == 0) else begin
					$display("ERROR: o_ready high at time %0t while a request is in flight",
						$time);
					abort_run();
				end
			end
			if (req_valid && ready) begin
				head.addr = req.addr;
				head.write = req.write;
				head.wdata = req.wdata;
				head.exp_data = expected_word(req.addr);
				pending.push_back(head);
				// Write-through means memory holds the new word from now on
				if (req.write) begin
					mem_image[int'(req.addr) % IMAGE_DEPTH] = req.wdata;
				end
				accept_cycle = cycle_cnt;
				mem_seen = 1'b0;
			end
		end
	end

	initial begin : stimulus
		addr_t       addr;
		word_t       wdata;
		logic [31:0] rnd;
		int          mem_before;
		seed = 6;
		rst_n = 1'b0;
		req_valid = 1'b0;
		req = '0;
		snoop_valid = 1'b0;
		snoop_addr = '0;
		for (int i = 0; i < IMAGE_DEPTH; i++) begin
			mem_image[i] = fill_word(i);
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		assert (ready && !rsp_valid && !mem_req_valid) else begin
			$display("ERROR: outputs not in their idle state after reset");
			abort_run();
		end

		// Cold read misses with one request at the critical word
		mem_before = mem_req_cnt;
		issue_request(make_addr(1, 1'b0, 2), 1'b0, '0);
		assert (mem_req_cnt == mem_before + 1) else begin
			$display("ERROR: read after reset did not issue exactly one memory request");
			abort_run();
		end

		// Same line again hits
		mem_before = mem_req_cnt;
		issue_request(make_addr(1, 1'b0, 0), 1'b0, '0);
		assert (mem_req_cnt == mem_before) else begin
			$display("ERROR: read hit issued a memory request");
			abort_run();
		end
		assert (last_latency == 2) else begin
			$display("MISMATCH time=%0t o_rsp_valid latency got=%0d expected=2",
				$time, last_latency);
			abort_run();
		end

		// Write hit then read back
		mem_before = mem_req_cnt;
		issue_request(make_addr(1, 1'b0, 1), 1'b1, 32'hDEAD_BEEF);
		assert (mem_req_cnt == mem_before + 1) else begin
			$display("ERROR: write did not reach memory");
			abort_run();
		end
		issue_request(make_addr(1, 1'b0, 1), 1'b0, '0);

		// Write miss does not allocate
		issue_request(make_addr(2, 1'b1, 3), 1'b1, 32'h1234_5678);
		mem_before = mem_req_cnt;
		issue_request(make_addr(2, 1'b1, 3), 1'b0, '0);
		assert (mem_req_cnt == mem_before + 1) else begin
			$display("ERROR: read after a write miss did not fetch the line");
			abort_run();
		end

		// Snoop drops the cached line
		issue_snoop(make_addr(1, 1'b0, 0));
		mem_before = mem_req_cnt;
		issue_request(make_addr(1, 1'b0, 3), 1'b0, '0);
		assert (mem_req_cnt == mem_before + 1) else begin
			$display("ERROR: read after a snoop hit did not miss");
			abort_run();
		end

		// Eight tags over two sets force evictions
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $random(seed);
			addr = make_addr(int'(rnd[6:4]), rnd[7], int'(rnd[9:8]));
			if (rnd[3:0] < 4'd9) begin
				issue_request(addr, 1'b0, '0);
			end else if (rnd[3:0] < 4'd14) begin
				wdata = $random(seed);
				issue_request(addr, 1'b1, wdata);
			end else begin
				issue_snoop(addr);
			end
		end

		while (!ready) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		$display("Requests %0d, memory requests %0d, cycles %0d",
			issue_cnt, mem_req_cnt, cycle_cnt);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/mem_model.sv
`default_nettype none

module mem_model #(
	parameter int IMAGE_DEPTH = 8192
) (
	input  logic                   clk_i,
	input  logic                   i_req_valid,
	input  l1_cache_pkg::mem_req_t i_req,
	input  l1_cache_pkg::word_t    i_image [IMAGE_DEPTH],
	output logic                   o_rsp_valid,
	output l1_cache_pkg::mem_rsp_t o_rsp
);
	import l1_cache_pkg::*;

	mem_req_t req_q;
	addr_t    beat_addr;
	int       delay;
	int       req_cnt;

	// Requests are sampled and beats driven on the falling edge
	initial begin
		o_rsp_valid = 1'b0;
		o_rsp = '0;
		req_cnt = 0;
		forever begin
			@(negedge clk_i);
			if (i_req_valid) begin
				req_q = i_req;
				// Turnaround of zero to two idle cycles
				delay = req_cnt % 3;
				req_cnt++;
				repeat (delay) begin
					@(negedge clk_i);
				end
				if (req_q.write) begin
					// One beat acknowledges a write
					o_rsp_valid = 1'b1;
					o_rsp.data = '0;
					@(negedge clk_i);
				end else begin
					beat_addr = req_q.addr;
					for (int b = 0; b < WORDS_PER_LINE; b++) begin
						o_rsp_valid = 1'b1;
						o_rsp.data = i_image[int'(beat_addr) % IMAGE_DEPTH];
						@(negedge clk_i);
						// Wrap inside the line, critical word first
						beat_addr[WORD_SEL_W-1:0] += word_sel_t'(1);
					end
				end
				o_rsp_valid = 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/l1_cache_top.sv
`default_nettype none

module l1_cache_top (
	input  logic                   clk_i,
	input  logic                   rst_n,
	input  logic                   i_req_valid,
	input  l1_cache_pkg::cpu_req_t i_req,
	output logic                   o_ready,
	output logic                   o_rsp_valid,
	output l1_cache_pkg::cpu_rsp_t o_rsp,
	output logic                   o_mem_req_valid,
	output l1_cache_pkg::mem_req_t o_mem_req,
	input  logic                   i_mem_rsp_valid,
	input  l1_cache_pkg::mem_rsp_t i_mem_rsp,
	input  logic                   i_snoop_valid,
	input  l1_cache_pkg::addr_t    i_snoop_addr
);
	import l1_cache_pkg::*;

	logic       snoop_busy;
	logic       ctrl_store_valid;
	store_req_t ctrl_store_req;
	logic       snoop_store_valid;
	store_req_t snoop_store_req;
	logic       hit;
	way_t       hit_way;
	line_t      hit_line;

	l1_cache_ctrl u_ctrl (
		.clk_i           (clk_i),
		.rst_n           (rst_n),
		.i_req_valid     (i_req_valid),
		.i_req           (i_req),
		.o_ready         (o_ready),
		.o_rsp_valid     (o_rsp_valid),
		.o_rsp           (o_rsp),
		.o_mem_req_valid (o_mem_req_valid),
		.o_mem_req       (o_mem_req),
		.i_mem_rsp_valid (i_mem_rsp_valid),
		.i_mem_rsp       (i_mem_rsp),
		.i_snoop_busy    (snoop_busy),
		.o_store_valid   (ctrl_store_valid),
		.o_store_req     (ctrl_store_req),
		.i_hit           (hit),
		.i_hit_way       (hit_way),
		.i_hit_line      (hit_line)
	);

	// Lookup results go to both requesters
	way_store u_way_store (
		.clk_i         (clk_i),
		.rst_n         (rst_n),
		.i_ctrl_valid  (ctrl_store_valid),
		.i_ctrl_req    (ctrl_store_req),
		.i_snoop_valid (snoop_store_valid),
		.i_snoop_req   (snoop_store_req),
		.o_hit         (hit),
		.o_hit_way     (hit_way),
		.o_hit_line    (hit_line)
	);

	snoop_unit u_snoop (
		.clk_i         (clk_i),
		.rst_n         (rst_n),
		.i_snoop_valid (i_snoop_valid),
		.i_snoop_addr  (i_snoop_addr),
		.o_store_valid (snoop_store_valid),
		.o_store_req   (snoop_store_req),
		.i_hit         (hit),
		.i_hit_way     (hit_way),
		.o_snoop_busy  (snoop_busy)
	);

endmodule

`default_nettype wire

// File: cache_ctrl/l1_cache_ctrl.sv
`default_nettype none

module l1_cache_ctrl (
	input  logic                     clk_i,
	input  logic                     rst_n,
	input  logic                     i_req_valid,
	input  l1_cache_pkg::cpu_req_t   i_req,
	output logic                     o_ready,
	output logic                     o_rsp_valid,
	output l1_cache_pkg::cpu_rsp_t   o_rsp,
	output logic                     o_mem_req_valid,
	output l1_cache_pkg::mem_req_t   o_mem_req,
	input  logic                     i_mem_rsp_valid,
	input  l1_cache_pkg::mem_rsp_t   i_mem_rsp,
	input  logic                     i_snoop_busy,
	output logic                     o_store_valid,
	output l1_cache_pkg::store_req_t o_store_req,
	input  logic                     i_hit,
	input  l1_cache_pkg::way_t       i_hit_way,
	input  l1_cache_pkg::line_t      i_hit_line
);
	import l1_cache_pkg::*;

	ctrl_state_e  state_q;
	addr_fields_t req_addr_q;
	logic         req_write_q;
	word_t        req_wdata_q;
	way_t         victim_q;
	way_t         fill_way_q;
	word_sel_t    beat_cnt_q;
	word_sel_t    beat_sel_q;
	line_t        fill_line_q;
	logic         fill_write_q;
	logic         accept;
	logic         last_beat;

	// No new request while a miss or a snoop is in progress
	assign o_ready = (state_q == CTRL_IDLE) && !i_snoop_busy;
	assign accept = i_req_valid && o_ready;
	assign last_beat = i_mem_rsp_valid && (beat_cnt_q == word_sel_t'(LAST_BEAT));

	// Round-robin victim pointer, advances every cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			victim_q <= '0;
		end else begin
			victim_q <= victim_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= CTRL_IDLE;
			o_rsp_valid <= 1'b0;
			o_mem_req_valid <= 1'b0;
			fill_write_q <= 1'b0;
			beat_cnt_q <= '0;
		end else begin
			o_rsp_valid <= 1'b0;
			o_mem_req_valid <= 1'b0;
			fill_write_q <= 1'b0;
			case (state_q)
				CTRL_IDLE: begin
					if (accept) begin
						state_q <= CTRL_LOOKUP;
					end
				end
				CTRL_LOOKUP: begin
					state_q <= CTRL_COMPARE;
				end
				CTRL_COMPARE: begin
					if (req_write_q) begin
						// Write-through, hit or miss
						o_mem_req_valid <= 1'b1;
						state_q <= CTRL_WRITE_ACK;
					end else if (i_hit) begin
						o_rsp_valid <= 1'b1;
						state_q <= CTRL_DONE;
					end else begin
						o_mem_req_valid <= 1'b1;
						beat_cnt_q <= '0;
						state_q <= CTRL_FILL_WAIT;
					end
				end
				CTRL_FILL_WAIT: begin
					if (i_mem_rsp_valid) begin
						beat_cnt_q <= beat_cnt_q + 1'b1;
						// Critical word goes straight back to the CPU
						if (beat_cnt_q == '0) begin
							o_rsp_valid <= 1'b1;
						end
						if (last_beat) begin
							fill_write_q <= 1'b1;
							state_q <= CTRL_IDLE;
						end
					end
				end
				CTRL_WRITE_ACK: begin
					if (i_mem_rsp_valid) begin
						o_rsp_valid <= 1'b1;
						state_q <= CTRL_IDLE;
					end
				end
				CTRL_DONE: begin
					state_q <= CTRL_IDLE;
				end
				default: begin
					state_q <= CTRL_IDLE;
				end
			endcase
		end
	end

	// Request, line buffer and response data
	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_addr_q <= i_req.addr;
			req_write_q <= i_req.write;
			req_wdata_q <= i_req.wdata;
		end
		case (state_q)
			CTRL_COMPARE: begin
				o_mem_req.addr <= addr_t'(req_addr_q);
				o_mem_req.write <= req_write_q;
				o_mem_req.wdata <= req_wdata_q;
				o_rsp.data <= i_hit_line[req_addr_q.word_sel];
				fill_way_q <= victim_q;
				beat_sel_q <= req_addr_q.word_sel;
			end
			CTRL_FILL_WAIT: begin
				if (i_mem_rsp_valid) begin
					// Beats wrap around the line from the critical word
					fill_line_q[beat_sel_q] <= i_mem_rsp.data;
					beat_sel_q <= beat_sel_q + 1'b1;
					if (beat_cnt_q == '0) begin
						o_rsp.data <= i_mem_rsp.data;
					end
				end
			end
			CTRL_WRITE_ACK: begin
				// Write completion echoes the stored word
				if (i_mem_rsp_valid) begin
					o_rsp.data <= req_wdata_q;
				end
			end
			default: begin
			end
		endcase
	end

	// Way store accesses: lookup, word update on a write hit, line fill
	always_comb begin
		o_store_valid = 1'b0;
		o_store_req.index = req_addr_q.index;
		o_store_req.tag = req_addr_q.tag;
		o_store_req.op = STORE_LOOKUP;
		o_store_req.way = fill_way_q;
		o_store_req.word_sel = req_addr_q.word_sel;
		o_store_req.data = fill_line_q;
		if (state_q == CTRL_LOOKUP) begin
			o_store_valid = 1'b1;
		end else if (state_q == CTRL_COMPARE && req_write_q && i_hit) begin
			o_store_valid = 1'b1;
			o_store_req.op = STORE_WRITE;
			o_store_req.way = i_hit_way;
			o_store_req.data = {WORDS_PER_LINE{req_wdata_q}};
		end else if (fill_write_q) begin
			o_store_valid = 1'b1;
			o_store_req.op = STORE_FILL;
		end
	end

endmodule

`default_nettype wire

// File: src/snoop_unit.sv
`default_nettype none

module snoop_unit (
	input  logic                     clk_i,
	input  logic                     rst_n,
	input  logic                     i_snoop_valid,
	input  l1_cache_pkg::addr_t      i_snoop_addr,
	output logic                     o_store_valid,
	output l1_cache_pkg::store_req_t o_store_req,
	input  logic                     i_hit,
	input  l1_cache_pkg::way_t       i_hit_way,
	output logic                     o_snoop_busy
);
	import l1_cache_pkg::*;

	snoop_state_e state_q;
	addr_fields_t addr_q;

	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			state_q <= SNOOP_IDLE;
		end else begin
			case (state_q)
				SNOOP_IDLE: begin
					if (i_snoop_valid) begin
						state_q <= SNOOP_LOOKUP;
					end
				end
				SNOOP_LOOKUP: state_q <= SNOOP_CHECK;
				default: state_q <= SNOOP_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state_q == SNOOP_IDLE && i_snoop_valid) begin
			addr_q <= i_snoop_addr;
		end
	end

	// Holds off the CPU side for the lookup and check cycles
	assign o_snoop_busy = (state_q != SNOOP_IDLE);

	always_comb begin
		o_store_valid = 1'b0;
		o_store_req.index = addr_q.index;
		o_store_req.tag = addr_q.tag;
		o_store_req.op = STORE_LOOKUP;
		o_store_req.way = i_hit_way;
		o_store_req.word_sel = addr_q.word_sel;
		o_store_req.data = '0;
		if (state_q == SNOOP_LOOKUP) begin
			o_store_valid = 1'b1;
		end else if (state_q == SNOOP_CHECK && i_hit) begin
			// Drop the matching line
			o_store_valid = 1'b1;
			o_store_req.op = STORE_INVAL;
		end
	end

endmodule

`default_nettype wire

// File: src/way_store.sv
`default_nettype none

module way_store (
	input  logic                     clk_i,
	input  logic                     rst_n,
	input  logic                     i_ctrl_valid,
	input  l1_cache_pkg::store_req_t i_ctrl_req,
	input  logic                     i_snoop_valid,
	input  l1_cache_pkg::store_req_t i_snoop_req,
	output logic                     o_hit,
	output l1_cache_pkg::way_t       o_hit_way,
	output l1_cache_pkg::line_t      o_hit_line
);
	import l1_cache_pkg::*;

	tag_t                                  tag_mem  [CACHE_WAYS][CACHE_SETS];
	logic [LINE_W-1:0]                     data_mem [CACHE_WAYS][CACHE_SETS];
	logic [CACHE_WAYS-1:0][CACHE_SETS-1:0] valid_q;

	tag_t                  rd_tag_q  [CACHE_WAYS];
	logic [LINE_W-1:0]     rd_line_q [CACHE_WAYS];
	logic [CACHE_WAYS-1:0] rd_valid_q;
	tag_t                  lookup_tag_q;
	store_req_t            req;
	logic                  req_valid;

	// Snoop wins, the controller is idle whenever it runs
	assign req = i_snoop_valid ? i_snoop_req : i_ctrl_req;
	assign req_valid = i_snoop_valid || i_ctrl_valid;

	always_ff @(posedge clk_i) begin
		if (req_valid) begin
			case (req.op)
				STORE_LOOKUP: begin
					for (int w = 0; w < CACHE_WAYS; w++) begin
						rd_tag_q[w] <= tag_mem[w][req.index];
						rd_line_q[w] <= data_mem[w][req.index];
					end
					lookup_tag_q <= req.tag;
				end
				STORE_FILL: begin
					tag_mem[req.way][req.index] <= req.tag;
					data_mem[req.way][req.index] <= req.data;
				end
				STORE_WRITE: begin
					data_mem[req.way][req.index][req.word_sel*DATA_W +: DATA_W] <=
						req.data[req.word_sel];
				end
				default: begin
				end
			endcase
		end
	end

	// Valid flags
	always_ff @(posedge clk_i) begin
		if (!rst_n) begin
			valid_q <= '0;
			rd_valid_q <= '0;
		end else if (req_valid) begin
			case (req.op)
				STORE_LOOKUP: begin
					for (int w = 0; w < CACHE_WAYS; w++) begin
						rd_valid_q[w] <= valid_q[w][req.index];
					end
				end
				STORE_FILL: valid_q[req.way][req.index] <= 1'b1;
				STORE_INVAL: valid_q[req.way][req.index] <= 1'b0;
				default: begin
				end
			endcase
		end
	end

	// Tag compare on the registered lookup
	always_comb begin
		o_hit = 1'b0;
		o_hit_way = '0;
		for (int w = 0; w < CACHE_WAYS; w++) begin
			if (rd_valid_q[w] && rd_tag_q[w] == lookup_tag_q) begin
				o_hit = 1'b1;
				o_hit_way = way_t'(w);
			end
		end
	end

	assign o_hit_line = line_t'(rd_line_q[o_hit_way]);

endmodule

`default_nettype wire

// File: common/l1_cache_pkg.sv
`default_nettype none

package l1_cache_pkg;

	// Cache geometry
	localparam int CACHE_WAYS = 4;
	localparam int CACHE_SETS = 256;
	localparam int WORDS_PER_LINE = 4;

	// Word-addressed, 32-bit data
	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;

	localparam int INDEX_W = $clog2(CACHE_SETS);
	localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);
	localparam int TAG_W = ADDR_W - INDEX_W - WORD_SEL_W;
	localparam int WAY_W = $clog2(CACHE_WAYS);
	localparam int LINE_W = WORDS_PER_LINE * DATA_W;

	// Beat number of the final word of a fill
	localparam int LAST_BEAT = WORDS_PER_LINE - 1;

	typedef logic [INDEX_W-1:0]    index_t;
	typedef logic [TAG_W-1:0]      tag_t;
	typedef logic [WORD_SEL_W-1:0] word_sel_t;
	typedef logic [WAY_W-1:0]      way_t;
	typedef logic [DATA_W-1:0]     word_t;
	typedef logic [ADDR_W-1:0]     addr_t;

	// Word 0 sits in the low bits of the line
	typedef word_t [WORDS_PER_LINE-1:0] line_t;

	// Word address split into its cache fields
	typedef struct packed {
		tag_t      tag;
		index_t    index;
		word_sel_t word_sel;
	} addr_fields_t;

	typedef struct packed {
		addr_t addr;
		logic  write;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		word_t data;
	} cpu_rsp_t;

	// For a fill, addr is the critical word
	typedef struct packed {
		addr_t addr;
		logic  write;
		word_t wdata;
	} mem_req_t;

	typedef struct packed {
		word_t data;
	} mem_rsp_t;

	typedef enum logic [1:0] {
		STORE_LOOKUP,
		STORE_FILL,
		STORE_WRITE,
		STORE_INVAL
	} store_op_e;

	// A word write takes its data from the lane picked by word_sel
	typedef struct packed {
		index_t    index;
		tag_t      tag;
		store_op_e op;
		way_t      way;
		word_sel_t word_sel;
		line_t     data;
	} store_req_t;

	typedef enum logic [2:0] {
		CTRL_IDLE,
		CTRL_LOOKUP,
		CTRL_COMPARE,
		CTRL_FILL_WAIT,
		CTRL_WRITE_ACK,
		CTRL_DONE
	} ctrl_state_e;

	typedef enum logic [1:0] {
		SNOOP_IDLE,
		SNOOP_LOOKUP,
		SNOOP_CHECK
	} snoop_state_e;

endpackage

`default_nettype wire
